// ==== logic/exec_pkg.sv ====
package exec_pkg;

    //////////////////////////////////////////////////
    // Data path and bookkeeping widths
    //////////////////////////////////////////////////
    localparam int XLEN       = 32;
    localparam int SHAMT_W    = $clog2(XLEN);
    localparam int THREAD_NUM = 2;
    localparam int ROB_IDX_W  = 5;
    localparam int TAG_W      = 6;

    // Cycles from accept to result valid, 1 to 3 supported
    localparam int EX_CYCLE   = 2;

    typedef logic [XLEN-1:0]               word_t;
    typedef logic [$clog2(THREAD_NUM)-1:0] thread_idx_t;
    typedef logic [ROB_IDX_W-1:0]          rob_idx_t;
    typedef logic [TAG_W-1:0]              tag_t;
    typedef logic [2:0]                    funct3_t;

    // Branch compare codes from inst[14:12]
    localparam funct3_t BR_BEQ  = 3'b000;
    localparam funct3_t BR_BNE  = 3'b001;
    localparam funct3_t BR_BLT  = 3'b100;
    localparam funct3_t BR_BGE  = 3'b101;
    localparam funct3_t BR_BLTU = 3'b110;
    localparam funct3_t BR_BGEU = 3'b111;

    //////////////////////////////////////////////////
    // Operand selects and ALU function
    //////////////////////////////////////////////////
    typedef enum logic [1:0] {
        OPA_IS_RS1,
        OPA_IS_NPC,
        OPA_IS_PC,
        OPA_IS_ZERO
    } opa_sel_e;

    // Immediate forms follow the RV32I encodings
    typedef enum logic [2:0] {
        OPB_IS_RS2,
        OPB_IS_I_IMM,
        OPB_IS_S_IMM,
        OPB_IS_B_IMM,
        OPB_IS_U_IMM,
        OPB_IS_J_IMM
    } opb_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_func_e;

endpackage

// ==== logic/alu_core.sv ====
`timescale 1ns/100ps

module alu_core (
    input  exec_pkg::word_t     opa_i,
    input  exec_pkg::word_t     opb_i,
    input  exec_pkg::alu_func_e func_i,
    output exec_pkg::word_t     result_o
);
    import exec_pkg::*;

    // Signed views for SLT and SRA
    logic signed [XLEN-1:0] opa_s;
    logic signed [XLEN-1:0] opb_s;
    logic [SHAMT_W-1:0]     shamt;
    logic                   lt_signed;
    logic                   lt_unsigned;

    assign opa_s = opa_i;
    assign opb_s = opb_i;

    // Only the low bits of B count for shifts
    assign shamt = opb_i[SHAMT_W-1:0];

    assign lt_signed   = opa_s < opb_s;
    assign lt_unsigned = opa_i < opb_i;

    always_comb begin
        case (func_i)
            ALU_ADD:  result_o = opa_i + opb_i;
            ALU_SUB:  result_o = opa_i - opb_i;
            ALU_AND:  result_o = opa_i & opb_i;
            ALU_OR:   result_o = opa_i | opb_i;
            ALU_XOR:  result_o = opa_i ^ opb_i;
            // Compares give 0 or 1 in bit 0
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_SLL:  result_o = opa_i << shamt;
            ALU_SRL:  result_o = opa_i >> shamt;
            // Sign bit fills from the left
            ALU_SRA:  result_o = opa_s >>> shamt;
            default:  result_o = '0;
        endcase
    end

endmodule

// ==== logic/operand_select.sv ====
`timescale 1ns/100ps

module operand_select (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  accept_i,
    input  exec_pkg::word_t       inst_i,
    input  exec_pkg::word_t       pc_i,
    input  exec_pkg::word_t       npc_i,
    input  exec_pkg::word_t       rs1_value_i,
    input  exec_pkg::word_t       rs2_value_i,
    input  exec_pkg::opa_sel_e    opa_sel_i,
    input  exec_pkg::opb_sel_e    opb_sel_i,
    input  exec_pkg::alu_func_e   alu_func_i,
    input  logic                  cond_br_i,
    input  logic                  uncond_br_i,
    input  exec_pkg::tag_t        tag_i,
    input  exec_pkg::rob_idx_t    rob_idx_i,
    input  exec_pkg::thread_idx_t thread_idx_i,
    output exec_pkg::word_t       opa_o,
    output exec_pkg::word_t       opb_o,
    output exec_pkg::alu_func_e   alu_func_o,
    output exec_pkg::funct3_t     funct3_o,
    output exec_pkg::word_t       rs1_o,
    output exec_pkg::word_t       rs2_o,
    output exec_pkg::word_t       pc_o,
    output exec_pkg::word_t       npc_o,
    output logic                  cond_br_o,
    output logic                  uncond_br_o,
    output exec_pkg::tag_t        tag_o,
    output exec_pkg::rob_idx_t    rob_idx_o,
    output exec_pkg::thread_idx_t thread_idx_o
);
    import exec_pkg::*;

    word_t     inst_q;
    opa_sel_e  opa_sel_q;
    opb_sel_e  opb_sel_q;

    //////////////////////////////////////////////////
    // Held instruction
    //////////////////////////////////////////////////

    // Branch flags and thread steer the squash and result fields
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cond_br_o    <= 1'b0;
            uncond_br_o  <= 1'b0;
            thread_idx_o <= '0;
        end else if (accept_i) begin
            cond_br_o    <= cond_br_i;
            uncond_br_o  <= uncond_br_i;
            thread_idx_o <= thread_idx_i;
        end
    end

    // Payload, loaded on accept only
    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            inst_q     <= inst_i;
            pc_o       <= pc_i;
            npc_o      <= npc_i;
            rs1_o      <= rs1_value_i;
            rs2_o      <= rs2_value_i;
            opa_sel_q  <= opa_sel_i;
            opb_sel_q  <= opb_sel_i;
            alu_func_o <= alu_func_i;
            tag_o      <= tag_i;
            rob_idx_o  <= rob_idx_i;
        end
    end

    assign funct3_o = inst_q[14:12];

    //////////////////////////////////////////////////
    // Operand multiplexers
    //////////////////////////////////////////////////
    always_comb begin
        case (opa_sel_q)
            OPA_IS_RS1: opa_o = rs1_o;
            OPA_IS_NPC: opa_o = npc_o;
            OPA_IS_PC:  opa_o = pc_o;
            default:    opa_o = '0;
        endcase
    end

    // Immediates sign extended from bit 31
    always_comb begin
        case (opb_sel_q)
            OPB_IS_RS2:   opb_o = rs2_o;
            OPB_IS_I_IMM: opb_o = {{20{inst_q[31]}}, inst_q[31:20]};
            OPB_IS_S_IMM: opb_o = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
            OPB_IS_B_IMM: opb_o = {{19{inst_q[31]}}, inst_q[31], inst_q[7],
                                   inst_q[30:25], inst_q[11:8], 1'b0};
            // Upper immediate, low 12 bits zero
            OPB_IS_U_IMM: opb_o = {inst_q[31:12], 12'b0};
            OPB_IS_J_IMM: opb_o = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12],
                                   inst_q[20], inst_q[30:21], 1'b0};
            default:      opb_o = '0;
        endcase
    end

endmodule

// ==== logic/latency_tracker.sv ====
`timescale 1ns/100ps

module latency_tracker (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               issue_valid_i,
    input  logic                               broadcast_i,
    input  exec_pkg::thread_idx_t              thread_idx_i,
    input  logic [exec_pkg::THREAD_NUM-1:0]    br_mis_i,
    input  logic                               exception_i,
    output logic                               accept_o,
    output logic                               issue_ready_o,
    output logic                               result_valid_o
);
    import exec_pkg::*;

    // One marker bit per execute stage
    logic [EX_CYCLE-1:0] valid_sh;
    logic [EX_CYCLE-1:0] valid_sh_nxt;
    logic                squash;
    logic                stall;
    logic                ex_end;

    // Mispredict on the held instruction's thread
    assign squash = br_mis_i[thread_idx_i];

    assign result_valid_o = valid_sh[EX_CYCLE-1] && !squash;

    // Result waiting on the broadcaster
    assign stall  = result_valid_o && !broadcast_i;
    assign ex_end = result_valid_o && broadcast_i;

    // Free when empty or the held result leaves this cycle
    assign issue_ready_o = (valid_sh == '0) || ex_end;
    assign accept_o      = issue_valid_i && issue_ready_o;

    //////////////////////////////////////////////////
    // Marker shift register
    //////////////////////////////////////////////////
    always_comb begin
        if (squash) begin
            valid_sh_nxt = '0;
        end else begin
            valid_sh_nxt = valid_sh << 1;
        end
        // New accept survives a squash
        valid_sh_nxt[0] = accept_o;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_sh <= '0;
        end else if (exception_i) begin
            // Flush everything in flight
            valid_sh <= '0;
        end else if (!stall) begin
            valid_sh <= valid_sh_nxt;
        end
    end

endmodule

// ==== logic/branch_resolve.sv ====
`timescale 1ns/100ps

module branch_resolve (
    input  exec_pkg::word_t   rs1_i,
    input  exec_pkg::word_t   rs2_i,
    input  exec_pkg::funct3_t funct3_i,
    input  logic              cond_br_i,
    input  logic              uncond_br_i,
    input  exec_pkg::word_t   alu_result_i,
    input  exec_pkg::word_t   npc_i,
    output logic              br_inst_o,
    output logic              br_result_o,
    output exec_pkg::word_t   br_target_o,
    output logic              write_reg_o,
    output exec_pkg::word_t   value_o
);
    import exec_pkg::*;

    logic signed [XLEN-1:0] rs1_s;
    logic signed [XLEN-1:0] rs2_s;
    logic                   cond_hit;

    assign rs1_s = rs1_i;
    assign rs2_s = rs2_i;

    // Compare on the raw register values
    always_comb begin
        case (funct3_i)
            BR_BEQ:  cond_hit = rs1_i == rs2_i;
            BR_BNE:  cond_hit = rs1_i != rs2_i;
            BR_BLT:  cond_hit = rs1_s <  rs2_s;
            BR_BGE:  cond_hit = rs1_s >= rs2_s;
            BR_BLTU: cond_hit = rs1_i <  rs2_i;
            BR_BGEU: cond_hit = rs1_i >= rs2_i;
            default: cond_hit = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // Result fields
    //////////////////////////////////////////////////
    assign br_inst_o   = cond_br_i || uncond_br_i;
    // Jumps always taken
    assign br_result_o = uncond_br_i || (cond_br_i && cond_hit);
    // Target comes from the shared adder
    assign br_target_o = br_inst_o ? alu_result_i : '0;

    // Link value for jumps, plain ALU result otherwise
    assign value_o     = br_inst_o ? npc_i : alu_result_i;
    assign write_reg_o = br_inst_o ? uncond_br_i : 1'b1;

endmodule

// ==== logic/exec_unit.sv ====
`timescale 1ns/100ps

module exec_unit (
    input  logic                            clk_i,
    input  logic                            rst_i,
    // Issue side
    input  logic                            issue_valid_i,
    output logic                            issue_ready_o,
    input  exec_pkg::word_t                 inst_i,
    input  exec_pkg::word_t                 pc_i,
    input  exec_pkg::word_t                 npc_i,
    input  exec_pkg::word_t                 rs1_value_i,
    input  exec_pkg::word_t                 rs2_value_i,
    input  exec_pkg::opa_sel_e              opa_sel_i,
    input  exec_pkg::opb_sel_e              opb_sel_i,
    input  exec_pkg::alu_func_e             alu_func_i,
    input  logic                            cond_br_i,
    input  logic                            uncond_br_i,
    input  exec_pkg::tag_t                  tag_i,
    input  exec_pkg::rob_idx_t              rob_idx_i,
    input  exec_pkg::thread_idx_t           thread_idx_i,
    // Broadcast side
    output logic                            result_valid_o,
    output exec_pkg::word_t                 result_pc_o,
    output exec_pkg::word_t                 result_value_o,
    output logic                            result_write_reg_o,
    output exec_pkg::tag_t                  result_tag_o,
    output exec_pkg::rob_idx_t              result_rob_idx_o,
    output exec_pkg::thread_idx_t           result_thread_idx_o,
    output logic                            br_inst_o,
    output logic                            br_result_o,
    output exec_pkg::word_t                 br_target_o,
    input  logic                            broadcast_i,
    // Recovery
    input  logic [exec_pkg::THREAD_NUM-1:0] br_mis_i,
    input  logic                            exception_i
);
    import exec_pkg::*;

    logic      accept;
    word_t     opa;
    word_t     opb;
    alu_func_e alu_func;
    funct3_t   funct3;
    word_t     rs1;
    word_t     rs2;
    word_t     npc;
    logic      cond_br;
    logic      uncond_br;
    word_t     alu_result;

    //////////////////////////////////////////////////
    // Operand stage
    //////////////////////////////////////////////////
    operand_select u_operand_select (
        .clk_i        (clk_i),             .rst_i        (rst_i),
        .accept_i     (accept),            .inst_i       (inst_i),
        .pc_i         (pc_i),              .npc_i        (npc_i),
        .rs1_value_i  (rs1_value_i),       .rs2_value_i  (rs2_value_i),
        .opa_sel_i    (opa_sel_i),         .opb_sel_i    (opb_sel_i),
        .alu_func_i   (alu_func_i),        .cond_br_i    (cond_br_i),
        .uncond_br_i  (uncond_br_i),       .tag_i        (tag_i),
        .rob_idx_i    (rob_idx_i),         .thread_idx_i (thread_idx_i),
        .opa_o        (opa),               .opb_o        (opb),
        .alu_func_o   (alu_func),          .funct3_o     (funct3),
        .rs1_o        (rs1),               .rs2_o        (rs2),
        .pc_o         (result_pc_o),       .npc_o        (npc),
        .cond_br_o    (cond_br),           .uncond_br_o  (uncond_br),
        .tag_o        (result_tag_o),      .rob_idx_o    (result_rob_idx_o),
        .thread_idx_o (result_thread_idx_o)
    );

    alu_core u_alu_core (
        .opa_i    (opa),
        .opb_i    (opb),
        .func_i   (alu_func),
        .result_o (alu_result)
    );

    // Squash follows the held instruction's thread
    latency_tracker u_latency_tracker (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .issue_valid_i  (issue_valid_i),
        .broadcast_i    (broadcast_i),
        .thread_idx_i   (result_thread_idx_o),
        .br_mis_i       (br_mis_i),
        .exception_i    (exception_i),
        .accept_o       (accept),
        .issue_ready_o  (issue_ready_o),
        .result_valid_o (result_valid_o)
    );

    branch_resolve u_branch_resolve (
        .rs1_i        (rs1),               .rs2_i        (rs2),
        .funct3_i     (funct3),            .cond_br_i    (cond_br),
        .uncond_br_i  (uncond_br),         .alu_result_i (alu_result),
        .npc_i        (npc),               .br_inst_o    (br_inst_o),
        .br_result_o  (br_result_o),       .br_target_o  (br_target_o),
        .write_reg_o  (result_write_reg_o), .value_o     (result_value_o)
    );

endmodule

// ==== testbench/exec_unit_sva.sv ====
`timescale 1ns/100ps

module exec_unit_sva (
    input logic                clk_i,
    input logic                rst_i,
    input logic                issue_valid_i,
    input logic                issue_ready_o,
    input logic                result_valid_o,
    input logic                broadcast_i,
    input exec_pkg::word_t     result_pc_o,
    input exec_pkg::word_t     result_value_o,
    input exec_pkg::tag_t      result_tag_o,
    input exec_pkg::rob_idx_t  result_rob_idx_o
);

    // Held result frozen while the broadcaster stalls
    a_stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        result_valid_o && !broadcast_i |=> $stable(result_pc_o) && $stable(result_value_o)
            && $stable(result_tag_o) && $stable(result_rob_idx_o))
        else $error("Result fields changed during a broadcast stall");

    a_reset_idle: assert property (@(posedge clk_i) rst_i |=> !result_valid_o)
        else $error("result_valid_o high in the cycle after reset");

    // Held fields untouched while issue is blocked
    a_no_accept: assert property (@(posedge clk_i) disable iff (rst_i)
        issue_valid_i && !issue_ready_o |=> $stable(result_pc_o) && $stable(result_tag_o)
            && $stable(result_rob_idx_o))
        else $error("Instruction accepted while issue_ready_o was low");

endmodule

// ==== testbench/exec_unit_tb.sv ====
`timescale 1ns/100ps

module exec_unit_tb;
    import exec_pkg::*;

    logic                  clk_i;
    logic                  rst_i;
    logic                  issue_valid_i;
    logic                  issue_ready_o;
    word_t                 inst_i;
    word_t                 pc_i;
    word_t                 npc_i;
    word_t                 rs1_value_i;
    word_t                 rs2_value_i;
    opa_sel_e              opa_sel_i;
    opb_sel_e              opb_sel_i;
    alu_func_e             alu_func_i;
    logic                  cond_br_i;
    logic                  uncond_br_i;
    tag_t                  tag_i;
    rob_idx_t              rob_idx_i;
    thread_idx_t           thread_idx_i;
    logic                  result_valid_o;
    word_t                 result_pc_o;
    word_t                 result_value_o;
    logic                  result_write_reg_o;
    tag_t                  result_tag_o;
    rob_idx_t              result_rob_idx_o;
    thread_idx_t           result_thread_idx_o;
    logic                  br_inst_o;
    logic                  br_result_o;
    word_t                 br_target_o;
    logic                  broadcast_i;
    logic [THREAD_NUM-1:0] br_mis_i;
    logic                  exception_i;

    // Reference model, one pending instruction at most
    logic        pend;
    int          age;
    word_t       exp_pc;
    word_t       exp_value;
    word_t       exp_target;
    logic        exp_write;
    logic        exp_br_inst;
    logic        exp_br_result;
    tag_t        exp_tag;
    rob_idx_t    exp_rob;
    thread_idx_t exp_thread;
    int          n_drop;

    exec_unit u_exec_unit (.*);

    bind exec_unit exec_unit_sva u_exec_unit_sva (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .issue_valid_i    (issue_valid_i),
        .issue_ready_o    (issue_ready_o),
        .result_valid_o   (result_valid_o),
        .broadcast_i      (broadcast_i),
        .result_pc_o      (result_pc_o),
        .result_value_o   (result_value_o),
        .result_tag_o     (result_tag_o),
        .result_rob_idx_o (result_rob_idx_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // Model functions
    //////////////////////////////////////////////////
    function automatic word_t alu_model(alu_func_e f, word_t a, word_t b);
        case (f)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
            default:  return '0;
        endcase
    endfunction

    // Operand B, immediates built at their natural width then extended
    function automatic word_t opb_model(opb_sel_e s, word_t i, word_t rs2);
        logic [12:0] b_imm;
        logic [20:0] j_imm;
        b_imm = {i[31], i[7], i[30:25], i[11:8], 1'b0};
        j_imm = {i[31], i[19:12], i[20], i[30:21], 1'b0};
        case (s)
            OPB_IS_RS2:   return rs2;
            OPB_IS_I_IMM: return word_t'($signed(i[31:20]));
            OPB_IS_S_IMM: return word_t'($signed({i[31:25], i[11:7]}));
            OPB_IS_B_IMM: return word_t'($signed(b_imm));
            OPB_IS_U_IMM: return {i[31:12], 12'h000};
            OPB_IS_J_IMM: return word_t'($signed(j_imm));
            default:      return '0;
        endcase
    endfunction

    function automatic logic cond_model(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return !($signed(a) < $signed(b));
            3'b110:  return a < b;
            3'b111:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    // Expected result of the instruction on the issue inputs
    task automatic predict();
        word_t a;
        word_t alu;
        logic  br;
        case (opa_sel_i)
            OPA_IS_RS1: a = rs1_value_i;
            OPA_IS_NPC: a = npc_i;
            OPA_IS_PC:  a = pc_i;
            default:    a = '0;
        endcase
        alu = alu_model(alu_func_i, a, opb_model(opb_sel_i, inst_i, rs2_value_i));
        br  = cond_br_i || uncond_br_i;
        exp_br_inst   = br;
        exp_br_result = uncond_br_i
                        || (cond_br_i && cond_model(inst_i[14:12], rs1_value_i, rs2_value_i));
        exp_target    = alu;
        // Jumps link npc, branches write nothing
        exp_value     = br ? npc_i : alu;
        exp_write     = br ? uncond_br_i : 1'b1;
        exp_pc        = pc_i;
        exp_tag       = tag_i;
        exp_rob       = rob_idx_i;
        exp_thread    = thread_idx_i;
    endtask

    task automatic check_value(word_t actual, word_t expected, string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h",
                     $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus and per-cycle checking
    //////////////////////////////////////////////////
    task automatic drive_cycle(int bcast_pct, int recov_pct);
        word_t      r;
        logic [1:0] kind;
        logic [2:0] f;
        r    = $urandom();
        kind = 2'($urandom_range(2));
        f    = 3'($urandom_range(5));
        issue_valid_i = ($urandom_range(99) < 60);
        inst_i        = $urandom();
        // Only legal compare codes 0, 1, 4 to 7
        inst_i[14:12] = (f < 3'd2) ? f : f + 3'd2;
        pc_i          = {r[31:2], 2'b00};
        npc_i         = pc_i + 32'd4;
        rs1_value_i   = $urandom();
        // Equal registers now and then so BEQ and BGE hit
        rs2_value_i   = r[0] ? rs1_value_i : $urandom();
        opa_sel_i     = opa_sel_e'(2'($urandom_range(3)));
        opb_sel_i     = opb_sel_e'(3'($urandom_range(5)));
        alu_func_i    = alu_func_e'(4'($urandom_range(9)));
        cond_br_i     = (kind == 2'd1);
        uncond_br_i   = (kind == 2'd2);
        tag_i         = tag_t'($urandom());
        rob_idx_i     = rob_idx_t'($urandom());
        thread_idx_i  = thread_idx_t'($urandom_range(THREAD_NUM - 1));
        broadcast_i   = ($urandom_range(99) < bcast_pct);
        br_mis_i      = '0;
        exception_i   = 1'b0;
        if ($urandom_range(99) < recov_pct) begin
            if (r[1]) begin
                // May hit the other thread, which must not squash
                br_mis_i[thread_idx_t'($urandom_range(THREAD_NUM - 1))] = 1'b1;
            end else begin
                exception_i   = 1'b1;
                broadcast_i   = 1'b0;
                issue_valid_i = 1'b0;
            end
        end
    endtask

    // Compare outputs, then advance the model past the coming edge
    task automatic step_model();
        logic squash;
        logic rv_exp;
        squash = pend && br_mis_i[exp_thread];
        rv_exp = pend && (age >= EX_CYCLE) && !squash;
        check_value(32'(result_valid_o), 32'(rv_exp), "result_valid_o");
        check_value(32'(issue_ready_o), 32'(!pend || (rv_exp && broadcast_i)), "issue_ready_o");
        if (rv_exp) begin
            check_value(result_pc_o, exp_pc, "result_pc_o");
            check_value(result_value_o, exp_value, "result_value_o");
            check_value(32'(result_write_reg_o), 32'(exp_write), "result_write_reg_o");
            check_value(32'(result_tag_o), 32'(exp_tag), "result_tag_o");
            check_value(32'(result_rob_idx_o), 32'(exp_rob), "result_rob_idx_o");
            check_value(32'(result_thread_idx_o), 32'(exp_thread), "result_thread_idx_o");
            check_value(32'(br_inst_o), 32'(exp_br_inst), "br_inst_o");
            check_value(32'(br_result_o), 32'(exp_br_result), "br_result_o");
            if (exp_br_inst) begin
                check_value(br_target_o, exp_target, "br_target_o");
            end
        end
        if (rv_exp && broadcast_i) begin
            pend = 1'b0;
        end
        if (squash || (pend && exception_i)) begin
            n_drop++;
            pend = 1'b0;
        end
        // Age saturates while the result waits
        if (pend && age < EX_CYCLE) begin
            age++;
        end
        if (issue_valid_i && issue_ready_o) begin
            predict();
            pend = 1'b1;
            age  = 1;
        end
    endtask

    task automatic run_cycles(int cycles, int bcast_pct, int recov_pct);
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk_i);
            drive_cycle(bcast_pct, recov_pct);
            #1;
            step_model();
        end
    endtask

    // Idle issue, broadcaster always ready, until the model is empty
    task automatic drain();
        int waited;
        waited = 0;
        while (pend) begin
            if (waited == 20) begin
                $display("Timeout: the pending result was never broadcast");
                $display("Simulation failed");
                $fatal(1);
            end
            @(negedge clk_i);
            issue_valid_i = 1'b0;
            broadcast_i   = 1'b1;
            br_mis_i      = '0;
            exception_i   = 1'b0;
            #1;
            step_model();
            waited++;
        end
    endtask

    initial begin
        void'($urandom(64));
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        inst_i        = '0;
        pc_i          = '0;
        npc_i         = '0;
        rs1_value_i   = '0;
        rs2_value_i   = '0;
        opa_sel_i     = OPA_IS_RS1;
        opb_sel_i     = OPB_IS_RS2;
        alu_func_i    = ALU_ADD;
        cond_br_i     = 1'b0;
        uncond_br_i   = 1'b0;
        tag_i         = '0;
        rob_idx_i     = '0;
        thread_idx_i  = '0;
        broadcast_i   = 1'b0;
        br_mis_i      = '0;
        exception_i   = 1'b0;
        pend          = 1'b0;
        age           = 0;
        n_drop        = 0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // ALU ops, branches and latency with no stall
        run_cycles(300, 100, 0);
        // Random back-pressure
        run_cycles(300, 50, 0);
        // Mispredicts and exceptions on top
        run_cycles(400, 70, 12);
        drain();

        check_value(32'(n_drop > 0), 32'd1, "no instruction was squashed or flushed");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== exec_unit.f ====
logic/exec_pkg.sv
logic/alu_core.sv
logic/operand_select.sv
logic/latency_tracker.sv
logic/branch_resolve.sv
logic/exec_unit.sv
testbench/exec_unit_sva.sv
testbench/exec_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the exec_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module exec_unit_tb \
    -f exec_unit.f -o exec_unit_sim \
    && ./obj_dir/exec_unit_sim \
    || exit 1
